/* common/ptw_dmem_pkg.sv */
/* Shared widths, command codes and request types for the PTW to data cache
   adapter */

package ptw_dmem_pkg;

    // ------------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------------
    localparam int PADDR_W     = 40;
    localparam int XLEN        = 64;
    localparam int LINE_WORDS  = 4;
    localparam int LANE_W      = 2;
    localparam int OFFSET_W    = 5;
    localparam int SET_W       = 7;
    localparam int TAG_W       = PADDR_W - SET_W - OFFSET_W;
    localparam int CMD_W       = 5;
    localparam int TYP_W       = 3;

    // PTW command that turns into an atomic OR on the cache
    localparam logic [CMD_W-1:0] CMD_AMO_OR = 5'b01010;

    // Requests issued to the cache and not yet answered
    localparam int OUTSTANDING = 4;
    localparam int QPTR_W      = $clog2(OUTSTANDING);

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef enum logic {
        OP_LOAD,
        OP_AMO_OR
    } cache_op_e;

    typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;
    typedef logic [LINE_WORDS-1:0][7:0]      line_be_t;

    // Address as the cache sees it, from tag down to byte in word
    typedef struct packed {
        logic [TAG_W-1:0]           tag;
        logic [SET_W-1:0]           set_idx;
        logic [LANE_W-1:0]          lane;
        logic [OFFSET_W-LANE_W-1:0] byte_idx;
    } paddr_cache_t;

    typedef union packed {
        logic [PADDR_W-1:0] flat;
        paddr_cache_t       cache;
    } paddr_u;

    // Request from the page table walker
    typedef struct packed {
        paddr_u             addr;
        logic [CMD_W-1:0]   cmd;
        logic [TYP_W-1:0]   typ;
        logic [XLEN-1:0]    data;
    } ptw_req_t;

    // Line-wide request toward the data cache
    typedef struct packed {
        logic [SET_W+OFFSET_W-1:0] addr_offset;
        logic [TAG_W-1:0]          addr_tag;
        cache_op_e                 op;
        logic [TYP_W-1:0]          size;
        line_t                     wdata;
        line_be_t                  be;
    } cache_req_t;

    // Decoded item between the two request stages
    typedef struct packed {
        paddr_u             addr;
        cache_op_e          op;
        logic [TYP_W-1:0]   size;
        logic [XLEN-1:0]    data;
    } pipe_item_t;

endpackage

/* source/ptw_req_decode.sv */
/* PTW request stage, registers each accepted request and decodes the
   command into a cache operation */

`timescale 1ns/10ps

module ptw_req_decode (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic                    ptw_req_valid_i,
    input  ptw_dmem_pkg::ptw_req_t  ptw_req_i,
    output logic                    ptw_req_ready_o,

    output logic                    item_valid_o,
    output ptw_dmem_pkg::pipe_item_t item_o,
    input  logic                    item_ready_i
);

    logic                     item_valid_q;
    ptw_dmem_pkg::pipe_item_t item_q;
    ptw_dmem_pkg::pipe_item_t item_d;
    logic                     accept;

    // Free slot, or the held item leaves this cycle
    assign ptw_req_ready_o = !item_valid_q || item_ready_i;
    assign accept          = ptw_req_valid_i && ptw_req_ready_o;

    // ------------------------------------------------------------------------
    // Command decode
    // ------------------------------------------------------------------------
    always_comb begin
        item_d.addr = ptw_req_i.addr;
        item_d.size = ptw_req_i.typ;
        item_d.data = ptw_req_i.data;
        // Anything other than AMO-OR is read as a plain load
        if (ptw_req_i.cmd == ptw_dmem_pkg::CMD_AMO_OR) begin
            item_d.op = ptw_dmem_pkg::OP_AMO_OR;
        end else begin
            item_d.op = ptw_dmem_pkg::OP_LOAD;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            item_valid_q <= 1'b0;
        end else if (ptw_req_ready_o) begin
            item_valid_q <= ptw_req_valid_i;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            item_q <= item_d;
        end
    end

    assign item_valid_o = item_valid_q;
    assign item_o       = item_q;

    // Held item must not change while lane_pack is busy
    a_item_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        item_valid_o && !item_ready_i |=> item_valid_o && $stable(item_o)
    );

endmodule

/* source/lane_pack.sv */
/* Cache request stage, places the PTW word and its byte enables in the
   addressed lane and drives the cache request port */

`timescale 1ns/10ps

module lane_pack (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  logic                     item_valid_i,
    input  ptw_dmem_pkg::pipe_item_t item_i,
    output logic                     item_ready_o,

    input  logic                     credit_ok_i,

    output logic                     cache_req_valid_o,
    output ptw_dmem_pkg::cache_req_t cache_req_o,
    input  logic                     cache_req_ready_i
);

    logic                     req_valid_q;
    ptw_dmem_pkg::cache_req_t req_q;
    ptw_dmem_pkg::cache_req_t req_d;
    logic                     issue;

    // ------------------------------------------------------------------------
    // Address split and lane placement
    // ------------------------------------------------------------------------
    always_comb begin
        req_d.addr_offset = {item_i.addr.cache.set_idx,
                             item_i.addr.cache.lane,
                             item_i.addr.cache.byte_idx};
        req_d.addr_tag    = item_i.addr.cache.tag;
        req_d.op          = item_i.op;
        req_d.size        = item_i.size;
        for (int i = 0; i < ptw_dmem_pkg::LINE_WORDS; i++) begin
            if (int'(item_i.addr.cache.lane) == i) begin
                req_d.wdata[i] = item_i.data;
                // Loads write nothing
                req_d.be[i] = (item_i.op == ptw_dmem_pkg::OP_AMO_OR) ? 8'hff : 8'h00;
            end else begin
                req_d.wdata[i] = '0;
                req_d.be[i]    = 8'h00;
            end
        end
    end

    // Request is held back while the response queue is full
    assign cache_req_valid_o = req_valid_q && credit_ok_i;
    assign cache_req_o       = req_q;
    assign issue             = cache_req_valid_o && cache_req_ready_i;
    assign item_ready_o      = !req_valid_q || issue;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_valid_q <= 1'b0;
        end else if (item_ready_o) begin
            req_valid_q <= item_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (item_valid_i && item_ready_o) begin
            req_q <= req_d;
        end
    end

    a_be_amo_only : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cache_req_valid_o && (cache_req_o.op == ptw_dmem_pkg::OP_LOAD)
            |-> cache_req_o.be == '0
    );

    // Back-pressure from the cache holds the request steady
    a_req_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cache_req_valid_o && !cache_req_ready_i
            |=> cache_req_valid_o && $stable(cache_req_o)
    );

endmodule

/* source/rsp_word_select.sv */
/* Response path, queues the lane of every issued request and returns the
   matching 64-bit word of each line-wide cache response */

`timescale 1ns/10ps

module rsp_word_select (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            issue_i,
    input  ptw_dmem_pkg::cache_req_t        issue_req_i,
    output logic                            credit_ok_o,

    input  logic                            cache_rsp_valid_i,
    input  ptw_dmem_pkg::line_t             cache_rsp_data_i,

    output logic                            ptw_rsp_valid_o,
    output logic [ptw_dmem_pkg::XLEN-1:0]   ptw_rsp_data_o
);

    // ------------------------------------------------------------------------
    // Outstanding lane queue
    // ------------------------------------------------------------------------
    logic [ptw_dmem_pkg::LANE_W-1:0] lane_q [ptw_dmem_pkg::OUTSTANDING];
    logic [ptw_dmem_pkg::QPTR_W-1:0] wr_ptr_q;
    logic [ptw_dmem_pkg::QPTR_W-1:0] rd_ptr_q;
    logic [ptw_dmem_pkg::QPTR_W:0]   count_q;
    logic [ptw_dmem_pkg::LANE_W-1:0] issue_lane;

    logic                            rsp_valid_q;
    logic [ptw_dmem_pkg::XLEN-1:0]   rsp_data_q;

    // Word index sits at the top of the line offset
    assign issue_lane = issue_req_i.addr_offset[ptw_dmem_pkg::OFFSET_W-1 -:
                                                ptw_dmem_pkg::LANE_W];

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            lane_q[wr_ptr_q] <= issue_lane;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (issue_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (cache_rsp_valid_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({issue_i, cache_rsp_valid_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // MSB of the count is set only at OUTSTANDING entries
    assign credit_ok_o = !count_q[ptw_dmem_pkg::QPTR_W];

    // ------------------------------------------------------------------------
    // Word select, one cycle after the cache response
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= cache_rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cache_rsp_valid_i) begin
            rsp_data_q <= cache_rsp_data_i[lane_q[rd_ptr_q]];
        end
    end

    assign ptw_rsp_valid_o = rsp_valid_q;
    assign ptw_rsp_data_o  = rsp_data_q;

    // Every cache response answers an earlier issue
    a_no_orphan_rsp : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cache_rsp_valid_i |-> count_q != '0
    );

endmodule

/* source/ptw_dmem_bridge.sv */
/* PTW to data cache adapter, decode, lane packing and response word
   selection with several accesses in flight */

`timescale 1ns/10ps

module ptw_dmem_bridge (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // PTW request and response
    input  logic                            ptw_req_valid_i,
    input  ptw_dmem_pkg::ptw_req_t          ptw_req_i,
    output logic                            ptw_req_ready_o,
    output logic                            ptw_rsp_valid_o,
    output logic [ptw_dmem_pkg::XLEN-1:0]   ptw_rsp_data_o,

    // Data cache request and response
    output logic                            cache_req_valid_o,
    output ptw_dmem_pkg::cache_req_t        cache_req_o,
    input  logic                            cache_req_ready_i,
    input  logic                            cache_rsp_valid_i,
    input  ptw_dmem_pkg::line_t             cache_rsp_data_i
);

    logic                     item_valid;
    logic                     item_ready;
    ptw_dmem_pkg::pipe_item_t item;
    logic                     credit_ok;
    logic                     issue;

    assign issue = cache_req_valid_o && cache_req_ready_i;

    ptw_req_decode req_decode0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ptw_req_valid_i (ptw_req_valid_i),
        .ptw_req_i       (ptw_req_i),
        .ptw_req_ready_o (ptw_req_ready_o),
        .item_valid_o    (item_valid),
        .item_o          (item),
        .item_ready_i    (item_ready)
    );

    lane_pack lane_pack0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .item_valid_i      (item_valid),
        .item_i            (item),
        .item_ready_o      (item_ready),
        .credit_ok_i       (credit_ok),
        .cache_req_valid_o (cache_req_valid_o),
        .cache_req_o       (cache_req_o),
        .cache_req_ready_i (cache_req_ready_i)
    );

    rsp_word_select rsp_select0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .issue_i           (issue),
        .issue_req_i       (cache_req_o),
        .credit_ok_o       (credit_ok),
        .cache_rsp_valid_i (cache_rsp_valid_i),
        .cache_rsp_data_i  (cache_rsp_data_i),
        .ptw_rsp_valid_o   (ptw_rsp_valid_o),
        .ptw_rsp_data_o    (ptw_rsp_data_o)
    );

endmodule

/* verification/cache_model.sv */
/* Behavioral data cache line memory with random back-pressure and in-order
   responses after a random delay */

`timescale 1ns/10ps

module cache_model (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     slow_i,
    input  logic                     req_valid_i,
    input  ptw_dmem_pkg::cache_req_t req_i,
    output logic                     req_ready_o,
    output logic                     rsp_valid_o,
    output ptw_dmem_pkg::line_t      rsp_data_o
);

    localparam int LINES = 16;

    ptw_dmem_pkg::line_t mem [LINES];
    ptw_dmem_pkg::line_t rsp_line_q [$];
    int                  rsp_due_q [$];
    ptw_dmem_pkg::line_t old_line;
    logic [31:0]         rnd;
    logic [31:0]         hi;
    bit                  filled;
    int                  cycle;
    int                  last_due;
    int                  idx;
    int                  due;

    logic                ready_q     = 1'b0;
    logic                rsp_valid_q = 1'b0;
    ptw_dmem_pkg::line_t rsp_data_q  = '0;

    assign req_ready_o = ready_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Cache side changes on the falling edge, the DUT samples on the rising one
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            ready_q     = 1'b0;
            rsp_valid_q = 1'b0;
            cycle       = 0;
            last_due    = 0;
            if (!filled) begin
                rnd = 32'he797;
                for (int l = 0; l < LINES; l++) begin
                    for (int w = 0; w < ptw_dmem_pkg::LINE_WORDS; w++) begin
                        rnd = lcg_next(rnd);
                        hi  = rnd;
                        rnd = lcg_next(rnd);
                        mem[l][w] = {hi, rnd};
                    end
                end
                filled = 1'b1;
            end
        end else begin
            cycle = cycle + 1;
            if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle) begin
                rsp_valid_q = 1'b1;
                rsp_data_q  = rsp_line_q.pop_front();
                void'(rsp_due_q.pop_front());
            end else begin
                rsp_valid_q = 1'b0;
            end
            rnd     = lcg_next(rnd);
            ready_q = (rnd[9:8] != 2'b00);
            // Transfer happens on the next rising edge
            if (req_valid_i && ready_q) begin
                idx      = int'(req_i.addr_offset[ptw_dmem_pkg::OFFSET_W +: 4]);
                old_line = mem[idx];
                rnd      = lcg_next(rnd);
                due      = cycle + (slow_i ? 6 : 1 + int'(rnd[26:24]) % 6);
                // One response per cycle, kept in request order
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_line_q.push_back(old_line);
                rsp_due_q.push_back(due);
                for (int l = 0; l < ptw_dmem_pkg::LINE_WORDS; l++) begin
                    for (int b = 0; b < 8; b++) begin
                        if (req_i.be[l][b]) begin
                            mem[idx][l][b*8 +: 8] = old_line[l][b*8 +: 8] |
                                                    req_i.wdata[l][b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

/* verification/tb_ptw_dmem_bridge.sv */
/* Testbench for the PTW to data cache adapter, table driven requests
   checked against a reference memory */

`timescale 1ns/10ps

module tb_ptw_dmem_bridge;

    localparam int STIM_N  = 16;
    localparam int LINES   = 16;
    localparam int TIMEOUT = 300;

    // One table row, gap is idle cycles before the request is offered
    typedef struct packed {
        logic [ptw_dmem_pkg::PADDR_W-1:0] addr;
        logic [ptw_dmem_pkg::CMD_W-1:0]   cmd;
        logic [ptw_dmem_pkg::TYP_W-1:0]   typ;
        logic [ptw_dmem_pkg::XLEN-1:0]    data;
        logic [3:0]                       gap;
        logic                             slow;
    } stim_t;

    stim_t stim_tbl [STIM_N] = '{
        {40'h00_8000_0020, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b0},
        {40'h00_8000_0048, 5'h00, 3'd3, 64'h0,                   4'd1, 1'b0},
        {40'h00_8000_0048, 5'h0a, 3'd3, 64'h0000_0000_0000_0060, 4'd0, 1'b0},
        {40'h00_8000_0048, 5'h00, 3'd3, 64'h0,                   4'd2, 1'b0},
        {40'h12_3456_7858, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b0},
        {40'h12_3456_7858, 5'h0a, 3'd3, 64'h8000_0000_0000_00e1, 4'd0, 1'b0},
        {40'h12_3456_7858, 5'h00, 3'd2, 64'h0,                   4'd3, 1'b0},
        {40'h00_8000_01f0, 5'h01, 3'd3, 64'hdead_beef_0000_0007, 4'd1, 1'b0},
        // Back-to-back burst against slow responses
        {40'h00_8000_0100, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0108, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0110, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0118, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0108, 5'h0a, 3'd3, 64'h0000_0000_0f0f_0f0f, 4'd0, 1'b1},
        {40'h00_8000_0108, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0020, 5'h00, 3'd3, 64'h0,                   4'd0, 1'b1},
        {40'h00_8000_0020, 5'h0a, 3'd3, 64'h1,                   4'd0, 1'b1}
    };

    logic                          clk_i = 1'b1;
    logic                          rst_n_i;
    logic                          ptw_req_valid_i;
    ptw_dmem_pkg::ptw_req_t        ptw_req_i;
    logic                          ptw_req_ready_o;
    logic                          ptw_rsp_valid_o;
    logic [ptw_dmem_pkg::XLEN-1:0] ptw_rsp_data_o;
    logic                          cache_req_valid_o;
    ptw_dmem_pkg::cache_req_t      cache_req_o;
    logic                          cache_req_ready_i;
    logic                          cache_rsp_valid_i;
    ptw_dmem_pkg::line_t           cache_rsp_data_i;
    logic                          slow_mode;

    int                            err_cnt;
    int                            mon_err_cnt = 0;
    int                            timeout_cnt;
    bit                            aborted;
    logic [ptw_dmem_pkg::XLEN-1:0] exp_rsp [$];
    ptw_dmem_pkg::cache_req_t      exp_req [$];
    ptw_dmem_pkg::line_t           ref_mem [LINES];
    logic [ptw_dmem_pkg::XLEN-1:0] exp_word;
    ptw_dmem_pkg::cache_req_t      exp_issue;
    ptw_dmem_pkg::cache_req_t      held_req;
    bit                            held;

    always #2 clk_i = ~clk_i;

    ptw_dmem_bridge dut0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ptw_req_valid_i   (ptw_req_valid_i),
        .ptw_req_i         (ptw_req_i),
        .ptw_req_ready_o   (ptw_req_ready_o),
        .ptw_rsp_valid_o   (ptw_rsp_valid_o),
        .ptw_rsp_data_o    (ptw_rsp_data_o),
        .cache_req_valid_o (cache_req_valid_o),
        .cache_req_o       (cache_req_o),
        .cache_req_ready_i (cache_req_ready_i),
        .cache_rsp_valid_i (cache_rsp_valid_i),
        .cache_rsp_data_i  (cache_rsp_data_i)
    );

    cache_model cache0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .slow_i      (slow_mode),
        .req_valid_i (cache_req_valid_o),
        .req_i       (cache_req_o),
        .req_ready_o (cache_req_ready_i),
        .rsp_valid_o (cache_rsp_valid_i),
        .rsp_data_o  (cache_rsp_data_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_idle_outputs();
        if (ptw_req_ready_o !== 1'b1) begin
            err_cnt++;
            $display("CHECK FAILED ptw_req_ready_o: got 0x%0h, expected 0x1", ptw_req_ready_o);
        end
        if (cache_req_valid_o !== 1'b0) begin
            err_cnt++;
            $display("CHECK FAILED cache_req_valid_o: got 0x%0h, expected 0x0",
                     cache_req_valid_o);
        end
        if (ptw_rsp_valid_o !== 1'b0) begin
            err_cnt++;
            $display("CHECK FAILED ptw_rsp_valid_o: got 0x%0h, expected 0x0", ptw_rsp_valid_o);
        end
    endtask

    // Queues the expected request and word, then offers the request
    task automatic apply_entry(input stim_t s);
        ptw_dmem_pkg::cache_req_t er;
        int idx;
        int lane;
        int wait_cnt;
        idx  = int'(s.addr[ptw_dmem_pkg::OFFSET_W +: 4]);
        lane = int'(s.addr[ptw_dmem_pkg::OFFSET_W-1 -: ptw_dmem_pkg::LANE_W]);
        er             = '0;
        er.addr_offset = s.addr[ptw_dmem_pkg::SET_W+ptw_dmem_pkg::OFFSET_W-1:0];
        er.addr_tag    = s.addr[ptw_dmem_pkg::PADDR_W-1 -: ptw_dmem_pkg::TAG_W];
        er.op          = (s.cmd == ptw_dmem_pkg::CMD_AMO_OR) ? ptw_dmem_pkg::OP_AMO_OR
                                                             : ptw_dmem_pkg::OP_LOAD;
        er.size        = s.typ;
        er.wdata[lane] = s.data;
        if (er.op == ptw_dmem_pkg::OP_AMO_OR) begin
            er.be[lane] = 8'hff;
        end
        exp_req.push_back(er);
        // Old word comes back, an atomic OR then updates the line
        exp_rsp.push_back(ref_mem[idx][lane]);
        if (er.op == ptw_dmem_pkg::OP_AMO_OR) begin
            ref_mem[idx][lane] = ref_mem[idx][lane] | s.data;
        end
        slow_mode = s.slow;
        repeat (s.gap) @(negedge clk_i);
        ptw_req_valid_i     = 1'b1;
        ptw_req_i.addr.flat = s.addr;
        ptw_req_i.cmd       = s.cmd;
        ptw_req_i.typ       = s.typ;
        ptw_req_i.data      = s.data;
        wait_cnt = 0;
        #1;
        while (!ptw_req_ready_o && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            #1;
            wait_cnt++;
        end
        if (!ptw_req_ready_o) begin
            timeout_cnt++;
            aborted = 1'b1;
            $display("ERROR: timeout, ptw_req_ready_o stayed low for request at 0x%0h", s.addr);
        end
        @(negedge clk_i);
        ptw_req_valid_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Monitors, one step after the falling edge when all inputs have settled
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        #1;
        if (rst_n_i) begin
            if (ptw_rsp_valid_o) begin
                if (exp_rsp.size() == 0) begin
                    mon_err_cnt++;
                    $display("ERROR: PTW response with no request outstanding");
                end else begin
                    exp_word = exp_rsp.pop_front();
                    if (ptw_rsp_data_o !== exp_word) begin
                        mon_err_cnt++;
                        $display("CHECK FAILED ptw_rsp_data_o: got 0x%0h, expected 0x%0h",
                                 ptw_rsp_data_o, exp_word);
                    end
                end
            end
            if (cache_req_valid_o) begin
                if (held && cache_req_o !== held_req) begin
                    mon_err_cnt++;
                    $display("CHECK FAILED cache_req_o: got 0x%0h, expected 0x%0h",
                             cache_req_o, held_req);
                end
                if (cache_req_ready_i) begin
                    held = 1'b0;
                    if (exp_req.size() == 0) begin
                        mon_err_cnt++;
                        $display("ERROR: cache request issued that no table entry asked for");
                    end else begin
                        exp_issue = exp_req.pop_front();
                        if (cache_req_o !== exp_issue) begin
                            mon_err_cnt++;
                            $display("CHECK FAILED cache_req_o: got 0x%0h, expected 0x%0h",
                                     cache_req_o, exp_issue);
                        end
                    end
                end else begin
                    held     = 1'b1;
                    held_req = cache_req_o;
                end
            end else if (held) begin
                mon_err_cnt++;
                held = 1'b0;
                $display("ERROR: cache request valid dropped before the transfer");
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] hi;
        int          wait_cnt;
        rst_n_i         = 1'b0;
        ptw_req_valid_i = 1'b0;
        ptw_req_i       = '0;
        slow_mode       = 1'b0;
        err_cnt         = 0;
        timeout_cnt     = 0;
        aborted         = 1'b0;
        // Same fill sequence as the cache model
        rnd = 32'he797;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < ptw_dmem_pkg::LINE_WORDS; w++) begin
                rnd = lcg_next(rnd);
                hi  = rnd;
                rnd = lcg_next(rnd);
                ref_mem[l][w] = {hi, rnd};
            end
        end
        repeat (3) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_idle_outputs();
        end
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_idle_outputs();

        for (int i = 0; i < STIM_N && !aborted; i++) begin
            apply_entry(stim_tbl[i]);
        end

        wait_cnt = 0;
        while ((exp_rsp.size() != 0 || exp_req.size() != 0) && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (exp_rsp.size() != 0 || exp_req.size() != 0) begin
            timeout_cnt++;
            $display("ERROR: timeout, %0d requests and %0d responses still missing",
                     exp_req.size(), exp_rsp.size());
        end
        // Idle tail catches duplicated requests or responses
        repeat (10) @(negedge clk_i);

        $display("Result: %0d check errors, %0d timeouts", err_cnt + mon_err_cnt, timeout_cnt);
        if (err_cnt == 0 && mon_err_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
common/ptw_dmem_pkg.sv
source/ptw_req_decode.sv
source/lane_pack.sv
source/rsp_word_select.sv
source/ptw_dmem_bridge.sv
verification/cache_model.sv
verification/tb_ptw_dmem_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PTW to data cache adapter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_ptw_dmem_bridge \
    -Mdir obj_dir

./obj_dir/Vtb_ptw_dmem_bridge | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run reported failures, see sim.log"
    exit 1
fi

echo "Run finished, see sim.log"
